/* Bender.yml */
package:
  name: wei_cfg

sources:
  # Package first, then the blocks, then the top level
  - common/wei_pkg.sv
  - design/wei_gbf/wei_gbf.sv
  - design/wei_ctrl.sv
  - design/pec_wei_bank.sv
  - design/wei_cfg_top.sv

  - target: test
    files:
      - tb/tb_wei_cfg.sv

/* common/wei_pkg.sv */
// Shared sizes and FSM states; NUM_PEC may go up to 48, and GBF_DEPTH must cover NUM_PEC plus PIPE_DEPTH words
package wei_pkg;

    // ======================================================================
    // Array and buffer sizes
    // ======================================================================

    // PE clusters loaded per configuration run
    localparam int unsigned NUM_PEC = 8;
    // Index width for one PEC
    localparam int unsigned PEC_ID_W = $clog2(NUM_PEC);
    // Index of the final PEC, ends a run
    localparam logic [PEC_ID_W-1:0] LAST_PEC = PEC_ID_W'(NUM_PEC - 1);

    // One weight word
    localparam int unsigned WEI_W = 16;

    // Global weight buffer words
    localparam int unsigned GBF_DEPTH = 16;
    // Buffer address width
    localparam int unsigned GBF_AW = $clog2(GBF_DEPTH);

    // Read pipeline stages, also the number of priming fetches
    localparam int unsigned PIPE_DEPTH = 3;

    // ======================================================================
    // Controller states
    // ======================================================================

    // Bit 2 set on every priming state
    // Priming states walk a Gray-like path toward GETWEI
    typedef enum logic [2:0] {
        IDLE     = 3'b000,
        PREPIPE1 = 3'b100,
        PREPIPE2 = 3'b101,
        PREPIPE3 = 3'b111,
        GETWEI   = 3'b010
    } ctrl_state_e;

endpackage

/* design/pec_wei_bank.sv */
// Weight capture only; pec_busy stalls every slot at once and no PEC arithmetic is modelled
module pec_wei_bank (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [wei_pkg::NUM_PEC-1:0]           rdy_wei,
    // Back-pressure level shared by all slots
    input  logic                                  pec_busy,
    // Shared weight bus from the buffer
    input  logic [wei_pkg::WEI_W-1:0]             gbf_wei,
    output logic [wei_pkg::NUM_PEC-1:0]           get_wei,
    output logic [wei_pkg::NUM_PEC-1:0]           pec_load,
    output logic [wei_pkg::NUM_PEC*wei_pkg::WEI_W-1:0] pec_wei
);

    // Captured weight per PEC
    logic [wei_pkg::WEI_W-1:0] slot_wei [wei_pkg::NUM_PEC];

    // ======================================================================
    // Take strobe
    // ======================================================================

    // Slot answers right away unless the bank is stalled
    assign get_wei = rdy_wei & {wei_pkg::NUM_PEC{~pec_busy}};

    // ======================================================================
    // Capture registers
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < wei_pkg::NUM_PEC; i++) begin
                slot_wei[i] <= '0;
            end
        end else begin
            for (int i = 0; i < wei_pkg::NUM_PEC; i++) begin
                if (get_wei[i]) begin
                    slot_wei[i] <= gbf_wei;
                end
            end
        end
    end

    // Load strobe marks the cycle the new word is visible
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pec_load <= '0;
        end else begin
            pec_load <= get_wei;
        end
    end

    // PEC 0 in the low slice
    always_comb begin
        for (int i = 0; i < wei_pkg::NUM_PEC; i++) begin
            pec_wei[i*wei_pkg::WEI_W +: wei_pkg::WEI_W] = slot_wei[i];
        end
    end

endmodule

/* design/wei_cfg_top.sv */
// Buffer contents must be written before start; a start during a run is ignored
module wei_cfg_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    // Buffer write port
    input  logic                                       wr_en,
    input  logic [wei_pkg::GBF_AW-1:0]                 wr_addr,
    input  logic [wei_pkg::WEI_W-1:0]                  wr_data,
    // Run control
    input  logic                                       start,
    input  logic                                       pec_busy,
    // PEC side
    output logic [wei_pkg::NUM_PEC*wei_pkg::WEI_W-1:0] pec_wei,
    output logic [wei_pkg::NUM_PEC-1:0]                pec_load,
    output logic                                       done
);

    // ======================================================================
    // Internal strobes and data
    // ======================================================================

    logic                          fetch;
    logic                          restart;
    logic                          gbf_rdy;
    logic [wei_pkg::WEI_W-1:0]     gbf_wei;
    logic [wei_pkg::NUM_PEC-1:0]   rdy_wei;
    logic [wei_pkg::NUM_PEC-1:0]   get_wei;

    // Weight buffer with fetch pipeline
    wei_gbf gbf_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .fetch   (fetch),
        .restart (restart),
        .gbf_wei (gbf_wei),
        .gbf_rdy (gbf_rdy)
    );

    // Configuration sequencer
    wei_ctrl ctrl_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .gbf_rdy (gbf_rdy),
        .get_wei (get_wei),
        .rdy_wei (rdy_wei),
        .fetch   (fetch),
        .restart (restart),
        .done    (done)
    );

    // PEC weight registers
    pec_wei_bank bank_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rdy_wei  (rdy_wei),
        .pec_busy (pec_busy),
        .gbf_wei  (gbf_wei),
        .get_wei  (get_wei),
        .pec_load (pec_load),
        .pec_wei  (pec_wei)
    );

endmodule

/* design/wei_ctrl.sv */
// Start is ignored outside IDLE; done pulses with the load strobe of the last PEC
module wei_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    // Last buffer stage holds a word
    input  logic                         gbf_rdy,
    // Capture strobes back from the PEC bank
    input  logic [wei_pkg::NUM_PEC-1:0]  get_wei,
    output logic [wei_pkg::NUM_PEC-1:0]  rdy_wei,
    output logic                         fetch,
    output logic                         restart,
    output logic                         done
);

    wei_pkg::ctrl_state_e state;
    wei_pkg::ctrl_state_e next_state;

    // PEC currently being offered a word
    logic [wei_pkg::PEC_ID_W-1:0] pec_idx;

    logic priming;
    logic handoff;
    logic last_pec;

    // ======================================================================
    // Strobes
    // ======================================================================

    assign priming = (state == wei_pkg::PREPIPE1) || (state == wei_pkg::PREPIPE2) ||
                     (state == wei_pkg::PREPIPE3);

    // A word leaves stage 3 when a ready PEC takes it
    assign handoff  = (|rdy_wei) && (|get_wei);
    assign fetch    = priming || handoff;
    assign restart  = (state == wei_pkg::IDLE) && start;
    assign last_pec = (pec_idx == wei_pkg::LAST_PEC);

    // ======================================================================
    // State machine
    // ======================================================================

    always_comb begin
        next_state = state;
        case (state)
            wei_pkg::IDLE: begin
                if (start) begin
                    next_state = wei_pkg::PREPIPE1;
                end
            end
            wei_pkg::PREPIPE1: next_state = wei_pkg::PREPIPE2;
            wei_pkg::PREPIPE2: next_state = wei_pkg::PREPIPE3;
            wei_pkg::PREPIPE3: next_state = wei_pkg::GETWEI;
            wei_pkg::GETWEI: begin
                // Run ends once the last PEC takes its word
                if (handoff && last_pec) begin
                    next_state = wei_pkg::IDLE;
                end
            end
            default: next_state = wei_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= wei_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ======================================================================
    // PEC index, ready vector, done
    // ======================================================================

    // Advances per handoff, wraps back to PEC 0 at the end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pec_idx <= '0;
        end else if (restart) begin
            pec_idx <= '0;
        end else if (fetch && state == wei_pkg::GETWEI) begin
            pec_idx <= last_pec ? '0 : pec_idx + 1'b1;
        end
    end

    // Cleared after any get, so one idle cycle between PECs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_wei <= '0;
        end else if (|get_wei) begin
            rdy_wei <= '0;
        end else if (state == wei_pkg::GETWEI && gbf_rdy) begin
            rdy_wei <= {{(wei_pkg::NUM_PEC-1){1'b0}}, 1'b1} << pec_idx;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= (state == wei_pkg::GETWEI) && handoff && last_pec;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================

    a_rdy_onehot : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(rdy_wei)
    ) else $error("rdy_wei has more than one bit set");

    // Bank may only answer the PEC that was offered a word
    a_get_in_rdy : assert property (
        @(posedge clk) disable iff (!rst_n) (get_wei & ~rdy_wei) == '0
    ) else $error("get_wei set outside rdy_wei");

endmodule

/* design/wei_gbf/wei_gbf.sv */
// Buffer read address wraps at GBF_DEPTH; writes during a run may or may not be seen by pending fetches
module wei_gbf (
    input  logic                         clk,
    input  logic                         rst_n,
    // External write port
    input  logic                         wr_en,
    input  logic [wei_pkg::GBF_AW-1:0]   wr_addr,
    input  logic [wei_pkg::WEI_W-1:0]    wr_data,
    // Controller strobes
    input  logic                         fetch,
    input  logic                         restart,
    // Word at the last pipeline stage
    output logic [wei_pkg::WEI_W-1:0]    gbf_wei,
    output logic                         gbf_rdy
);

    // ======================================================================
    // Storage and read state
    // ======================================================================

    // Weight memory
    logic [wei_pkg::WEI_W-1:0] mem [wei_pkg::GBF_DEPTH];

    // Next address to pull into stage 1
    logic [wei_pkg::GBF_AW-1:0] rd_addr;

    // Stage 0 of the arrays is pipeline stage 1
    logic [wei_pkg::WEI_W-1:0] pipe_data [wei_pkg::PIPE_DEPTH];
    logic [wei_pkg::PIPE_DEPTH-1:0] pipe_vld;

    // ======================================================================
    // Memory write
    // ======================================================================

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ======================================================================
    // Read address counter
    // ======================================================================

    // Restart rewinds to word 0 for a fresh run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (restart) begin
            rd_addr <= '0;
        end else if (fetch) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // ======================================================================
    // Fetch pipeline
    // ======================================================================

    // Valid bits shift with fetch only
    // Restart drops any words left from an earlier run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pipe_vld <= '0;
        end else if (restart) begin
            pipe_vld <= '0;
        end else if (fetch) begin
            pipe_vld <= {pipe_vld[wei_pkg::PIPE_DEPTH-2:0], 1'b1};
        end
    end

    // Data path moves in lockstep with the valid bits
    always_ff @(posedge clk) begin
        if (fetch) begin
            pipe_data[0] <= mem[rd_addr];
            for (int i = 1; i < wei_pkg::PIPE_DEPTH; i++) begin
                pipe_data[i] <= pipe_data[i-1];
            end
        end
    end

    // Last stage doubles as the weight distributor
    assign gbf_wei = pipe_data[wei_pkg::PIPE_DEPTH-1];
    assign gbf_rdy = pipe_vld[wei_pkg::PIPE_DEPTH-1];

    // Restart only comes from IDLE, fetch never does
    a_fetch_restart_excl : assert property (
        @(posedge clk) disable iff (!rst_n) !(fetch && restart)
    ) else $error("fetch and restart high in the same cycle");

endmodule

/* tb/tb_wei_cfg.sv */
// Testbench drives wei_cfg_top on falling edges and samples only registered outputs there; no writes during a run
module tb_wei_cfg;

    timeunit 1ns;
    timeprecision 100ps;

    // ======================================================================
    // Sizes and run budget
    // ======================================================================

    localparam int NP = wei_pkg::NUM_PEC;
    localparam int W  = wei_pkg::WEI_W;
    localparam int AW = wei_pkg::GBF_AW;
    localparam int CW = NP * W;

    // Cycles for one batch of buffer writes
    localparam int WR_CYC   = NP + 1;
    // Start, priming, two cycles per PEC, settle
    localparam int RUN_CYC  = 1 + wei_pkg::PIPE_DEPTH + 1 + 2 * NP + 6;
    localparam int IDLE_CYC = 200;
    // Busy-free length of all tests
    localparam int NEED_CYC = 10 + 2 + 3 * (WR_CYC + RUN_CYC) + IDLE_CYC + 1 + RUN_CYC;
    localparam int TIMEOUT_CYC = 4 * NEED_CYC + 200;

    // ======================================================================
    // DUT signals
    // ======================================================================

    logic          clk = 1'b0;
    logic          rst_n;
    logic          wr_en;
    logic [AW-1:0] wr_addr;
    logic [W-1:0]  wr_data;
    logic          start;
    logic          pec_busy;
    logic [CW-1:0] pec_wei;
    logic [NP-1:0] pec_load;
    logic          done;

    // ======================================================================
    // Model and bookkeeping
    // ======================================================================

    // Mirror of the buffer contents
    logic [W-1:0] model [wei_pkg::GBF_DEPTH];
    // Next PEC expected to load
    int exp_idx   = 0;
    int done_cnt  = 0;
    int err_cnt   = 0;
    int test_cnt  = 0;
    int cyc_count = 0;
    integer seed  = 32'h898b_7314;
    // Busy level seen by the edge just passed
    logic last_busy = 1'b0;
    wei_pkg::ctrl_state_e dbg_state;

    wei_cfg_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .start    (start),
        .pec_busy (pec_busy),
        .pec_wei  (pec_wei),
        .pec_load (pec_load),
        .done     (done)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cyc_count++;
        if (cyc_count >= TIMEOUT_CYC) begin
            dbg_state = dut_i.ctrl_i.state;
            $display("timeout: run did not end within %0d cycles, controller in %s",
                     TIMEOUT_CYC, dbg_state.name());
            $display("** FAIL **");
            $finish;
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic check_val(input string name, input logic [CW-1:0] exp_v,
                             input logic [CW-1:0] act_v);
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("error at %0d ns: %s expected %0h got %0h", $time, name, exp_v, act_v);
        end
    endtask

    // Compare the outputs of the last edge against the model
    task automatic observe_outputs();
        logic [NP-1:0] exp_load;
        if (pec_load != '0) begin
            if (last_busy) begin
                err_cnt++;
                $display("pec_load fired at %0d ns although pec_busy was high", $time);
            end
            if (exp_idx >= NP) begin
                err_cnt++;
                $display("pec_load fired at %0d ns after every PEC was loaded", $time);
            end else begin
                exp_load = '0;
                exp_load[exp_idx] = 1'b1;
                check_val("pec_load", exp_load, pec_load);
                check_val($sformatf("pec_wei[%0d]", exp_idx), model[exp_idx],
                          pec_wei[exp_idx*W +: W]);
            end
            exp_idx++;
        end
        // Last load and done may share a cycle
        if (done) begin
            done_cnt++;
            if (exp_idx != NP) begin
                err_cnt++;
                $display("done pulsed at %0d ns before all PECs were loaded", $time);
            end
        end
    endtask

    // One clock: check, then drive the next inputs
    task automatic drive_cycle(input logic we, input logic [AW-1:0] wa, input logic [W-1:0] wd,
                               input logic st, input logic busy);
        @(negedge clk);
        observe_outputs();
        wr_en    = we;
        wr_addr  = wa;
        wr_data  = wd;
        start    = st;
        pec_busy = busy;
        if (we) begin
            model[wa] = wd;
        end
        last_busy = busy;
    endtask

    // Fill the words the PECs will read; flip forces every word to change
    task automatic write_words(input bit flip);
        logic [31:0] r;
        logic [W-1:0] d;
        for (int a = 0; a < NP; a++) begin
            r = $random(seed);
            d = flip ? (model[a] ^ (r[W-1:0] | 1'b1)) : r[W-1:0];
            drive_cycle(1'b1, AW'(a), d, 1'b0, 1'b0);
        end
        drive_cycle(1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    // Full configuration run, optional extra start mid-run
    task automatic run_config(input bit rand_busy, input int extra_start_at);
        logic [31:0] r;
        int n;
        exp_idx  = 0;
        done_cnt = 0;
        n = 0;
        drive_cycle(1'b0, '0, '0, 1'b1, 1'b0);
        while (done_cnt == 0) begin
            n++;
            r = $random(seed);
            drive_cycle(1'b0, '0, '0, n == extra_start_at, rand_busy & r[0]);
        end
        // Quiet tail catches late loads or a second done
        repeat (4) drive_cycle(1'b0, '0, '0, 1'b0, 1'b0);
        check_val("load count", NP, exp_idx);
        check_val("done count", 1, done_cnt);
        for (int i = 0; i < NP; i++) begin
            check_val($sformatf("final pec_wei[%0d]", i), model[i], pec_wei[i*W +: W]);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [CW-1:0] snap;
        int errs;
        rst_n    = 1'b0;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        start    = 1'b0;
        pec_busy = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Reset values
        errs = err_cnt;
        check_val("pec_load", '0, pec_load);
        check_val("done", '0, done);
        check_val("pec_wei", '0, pec_wei);
        end_test("reset", errs);

        errs = err_cnt;
        write_words(1'b0);
        run_config(1'b0, 0);
        end_test("basic", errs);

        errs = err_cnt;
        write_words(1'b0);
        run_config(1'b1, 0);
        end_test("backpressure", errs);

        // Stale prefetched words must not leak into this run
        errs = err_cnt;
        write_words(1'b1);
        run_config(1'b0, 0);
        end_test("restart", errs);

        errs = err_cnt;
        // PECs keep the words of the last run
        for (int i = 0; i < NP; i++) begin
            snap[i*W +: W] = model[i];
        end
        for (int k = 0; k < IDLE_CYC; k++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            drive_cycle(r1[0], r2[AW-1:0], r3[W-1:0], 1'b0, r1[1]);
            check_val("pec_load", '0, pec_load);
            check_val("done", '0, done);
            check_val("pec_wei", snap, pec_wei);
        end
        drive_cycle(1'b0, '0, '0, 1'b0, 1'b0);
        // Second start lands in GETWEI and must be ignored
        run_config(1'b1, 5);
        end_test("idle", errs);

        $display("tests %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/wei_pkg.sv
design/wei_gbf/wei_gbf.sv
design/wei_ctrl.sv
design/pec_wei_bank.sv
design/wei_cfg_top.sv
tb/tb_wei_cfg.sv
